/* anim_if.sv */
// Requests are levels held by the controller, every done is a single-cycle pulse
`timescale 1ns/1ps
`default_nettype none

interface anim_ctrl_if import anim_pkg::*; ();
    logic  load_screen;
    step_t travel;        // Leg number while travelling, else 0
    step_t step;          // Current station, held through its step state
    logic  done_display;
    logic  done_travel;
    logic  done_step;

    modport ctrl   (output load_screen, travel, step,
                    input  done_display, done_travel, done_step);
    modport loader (input load_screen, output done_display);
    modport mover  (input travel, output done_travel);
    modport holder (input travel, step, output done_step);
endinterface

// One pixel write per cycle at most, no back-pressure
interface pixel_if import anim_pkg::*; ();
    coord_x_t x;
    coord_y_t y;
    colour_t  colour;
    logic     plot;

    modport source (output x, y, colour, plot);
    modport sink   (input  x, y, colour, plot);
endinterface

`default_nettype wire

/* anim_pkg.sv */
// Geometry assumes a 160x120 frame and five stations that fit left of column 152
`default_nettype none

package anim_pkg;

    typedef logic [7:0] coord_x_t;   // Pixel column
    typedef logic [6:0] coord_y_t;   // Pixel row
    typedef logic [2:0] colour_t;
    typedef logic [2:0] step_t;      // 0 is no step and 1 to 5 are the stations

    // Controller states in the order of a run
    typedef enum logic [3:0] {
        st_buffer, st_start,
        st_travel1, st_verify_amount,
        st_travel2, st_verify_signature,
        st_travel3, st_finalize_transaction,
        st_travel4, st_mine_block,
        st_travel5, st_update_chain,
        st_done_animation
    } anim_state_t;

    localparam int SCREEN_W      = 160;
    localparam int SCREEN_H      = 120;
    localparam int TOKEN_SIZE    = 4;
    localparam int PATH_Y        = 56;   // Top row of the token
    localparam int STATION_X0    = 8;
    localparam int STATION_PITCH = 28;
    localparam int BOX_SIZE      = 8;
    localparam int BOX_Y         = PATH_Y - 12;

    localparam int MOVE_CYCLES = 64;
    localparam int HOLD_CYCLES = 256;
    localparam int MOVE_W      = $clog2(MOVE_CYCLES);
    localparam int HOLD_W      = $clog2(HOLD_CYCLES);

    localparam colour_t COL_BG    = 3'd0;
    localparam colour_t COL_TOKEN = 3'd6;
    localparam colour_t COL_BOX   = 3'd2;

    // Left column of station k where station 0 is the start post
    function automatic coord_x_t station_x(input step_t k);
        return coord_x_t'(STATION_X0 + int'(k) * STATION_PITCH);
    endfunction

endpackage

`default_nettype wire

/* animation_checker.sv */
// Shadow model assumes start_animation is pulsed only while idle; error_count counts failures
`timescale 1ns/1ps
`default_nettype none

module animation_checker import anim_pkg::*; (
    input logic     clock,
    input logic     resetn,
    input logic     start_animation,
    input logic     return_signal,
    input coord_x_t pix_x,
    input coord_y_t pix_y,
    input colour_t  pix_colour,
    input logic     plot,
    input step_t    step,
    input logic     finished_transaction
);

    int unsigned error_count = 0;

    int       clear_cnt;       // Plots seen since start up to the frame size
    coord_x_t exp_x;
    coord_y_t exp_y;
    logic     idle;
    step_t    step_q;
    logic     await_return;    // Waiting in done_animation for return
    logic     exp_finish;
    logic     pending;
    int       station_lo;
    int       station_hi;

    assign pending    = ((step_q == 3'd5) && (step == 3'd0)) || await_return;
    assign station_lo = STATION_X0 + (int'(step) - 1) * STATION_PITCH;
    assign station_hi = STATION_X0 + int'(step) * STATION_PITCH;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            clear_cnt    <= SCREEN_W * SCREEN_H;
            exp_x        <= '0;
            exp_y        <= '0;
            idle         <= 1'b1;
            step_q       <= 3'd0;
            await_return <= 1'b0;
            exp_finish   <= 1'b0;
        end else begin
            step_q       <= step;
            exp_finish   <= pending && return_signal;
            await_return <= pending && !return_signal;
            if (finished_transaction) idle <= 1'b1;
            if (start_animation && idle) begin
                idle      <= 1'b0;
                clear_cnt <= 0;
                exp_x     <= '0;
                exp_y     <= '0;
            end else if (plot && clear_cnt < SCREEN_W * SCREEN_H) begin
                clear_cnt <= clear_cnt + 1;
                if (exp_x == coord_x_t'(SCREEN_W - 1)) begin
                    exp_x <= '0;
                    exp_y <= exp_y + 1'b1;
                end else begin
                    exp_x <= exp_x + 1'b1;
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clock)
        !resetn |=> (!plot && step == 3'd0 && !finished_transaction))
    else begin
        error_count = error_count + 1;
        $error("Mismatch after reset: plot %h step %h finished_transaction %h",
               $sampled(plot), $sampled(step), $sampled(finished_transaction));
    end

    a_clear_order: assert property (@(posedge clock) disable iff (!resetn)
        (plot && clear_cnt < SCREEN_W * SCREEN_H) |->
            (pix_colour == COL_BG && pix_x == exp_x && pix_y == exp_y))
    else begin
        error_count = error_count + 1;
        $error("Mismatch clear pixel: pix_x %h exp %h pix_y %h exp %h pix_colour %h exp %h",
               $sampled(pix_x), $sampled(exp_x), $sampled(pix_y), $sampled(exp_y),
               $sampled(pix_colour), COL_BG);
    end

    // Every write from any stage lands inside the frame
    a_plot_bounds: assert property (@(posedge clock) disable iff (!resetn)
        plot |-> (int'(pix_x) < SCREEN_W && int'(pix_y) < SCREEN_H))
    else begin
        error_count = error_count + 1;
        $error("Mismatch pixel bounds: pix_x %h pix_y %h", $sampled(pix_x), $sampled(pix_y));
    end

    // Travel must not begin before the whole frame is cleared
    a_clear_first: assert property (@(posedge clock) disable iff (!resetn)
        (step != 3'd0) |-> (clear_cnt == SCREEN_W * SCREEN_H))
    else begin
        error_count = error_count + 1;
        $error("Mismatch clear count: got %h expected %h", $sampled(clear_cnt),
               SCREEN_W * SCREEN_H);
    end

    a_step_order: assert property (@(posedge clock) disable iff (!resetn)
        (step != step_q) |-> (step == ((step_q == 3'd5) ? 3'd0 : step_q + 3'd1)))
    else begin
        error_count = error_count + 1;
        $error("Mismatch step: got %h after %h", $sampled(step), $sampled(step_q));
    end

    a_token_area: assert property (@(posedge clock) disable iff (!resetn)
        (plot && pix_colour == COL_TOKEN) |->
            (step != 3'd0
             && int'(pix_y) >= PATH_Y && int'(pix_y) < PATH_Y + TOKEN_SIZE
             && int'(pix_x) >= station_lo && int'(pix_x) < station_hi + TOKEN_SIZE))
    else begin
        error_count = error_count + 1;
        $error("Mismatch token pixel: pix_x %h pix_y %h step %h",
               $sampled(pix_x), $sampled(pix_y), $sampled(step));
    end

    a_box_area: assert property (@(posedge clock) disable iff (!resetn)
        (plot && pix_colour == COL_BOX) |->
            (step != 3'd0
             && int'(pix_x) >= station_hi && int'(pix_x) < station_hi + BOX_SIZE
             && int'(pix_y) >= PATH_Y - 12 && int'(pix_y) < PATH_Y - 12 + BOX_SIZE))
    else begin
        error_count = error_count + 1;
        $error("Mismatch box pixel: pix_x %h pix_y %h step %h",
               $sampled(pix_x), $sampled(pix_y), $sampled(step));
    end

    a_finish_pulse: assert property (@(posedge clock) disable iff (!resetn)
        finished_transaction == exp_finish)
    else begin
        error_count = error_count + 1;
        $error("Mismatch finished_transaction: got %h expected %h",
               $sampled(finished_transaction), $sampled(exp_finish));
    end

endmodule

bind animation_top animation_checker i_checker (
    .clock                (clock),
    .resetn               (resetn),
    .start_animation      (start_animation),
    .return_signal        (return_signal),
    .pix_x                (pix_x),
    .pix_y                (pix_y),
    .pix_colour           (pix_colour),
    .plot                 (plot),
    .step                 (step),
    .finished_transaction (finished_transaction)
);

`default_nettype wire

/* animation_tb.sv */
// Two full transactions with random return pulses; checking is done by the bound checker
`timescale 1ns/1ps
`default_nettype none

module animation_tb import anim_pkg::*; ();

    logic     clock;
    logic     resetn;
    logic     start_animation;
    logic     return_signal;
    coord_x_t pix_x;
    coord_y_t pix_y;
    colour_t  pix_colour;
    logic     plot;
    step_t    step;
    logic     finished_transaction;
    integer   seed;

    animation_top i_dut (
        .clock                (clock),
        .resetn               (resetn),
        .start_animation      (start_animation),
        .return_signal        (return_signal),
        .pix_x                (pix_x),
        .pix_y                (pix_y),
        .pix_colour           (pix_colour),
        .plot                 (plot),
        .step                 (step),
        .finished_transaction (finished_transaction)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;   // 8 ns period
    end

    // Upper bound for one hold plus one leg of travel
    function automatic int leg_budget();
        return (STATION_PITCH + 1) * (MOVE_CYCLES + 4 * TOKEN_SIZE * TOKEN_SIZE)
               + HOLD_CYCLES + 4 * BOX_SIZE * BOX_SIZE;
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on timeout");
    endtask

    task automatic pulse_start();
        start_animation = 1'b1;
        @(negedge clock);
        start_animation = 1'b0;
    endtask

    // Random return pulses while waiting, all of them must be ignored
    task automatic wait_for_step(input step_t target, input int limit);
        int count = 0;
        while (step !== target) begin
            if (count >= limit) report_timeout($sformatf("step to become %0d", target));
            @(negedge clock);
            return_signal = (($random(seed) & 32'hf) == 0);
            count++;
        end
        return_signal = 1'b0;
    endtask

    task automatic return_and_wait_finish();
        int count = 0;
        return_signal = 1'b1;
        while (finished_transaction !== 1'b1) begin
            if (count >= 16) report_timeout("finished_transaction after return_signal");
            @(negedge clock);
            count++;
        end
        return_signal = 1'b0;
    endtask

    // Stop at the first failed assertion
    always @(negedge clock) begin
        if (i_dut.i_checker.error_count != 0) begin
            $display("*** FAILED ***");
            $fatal(1, "Checker assertion failed");
        end
    end

    initial begin
        resetn          = 1'b0;
        start_animation = 1'b0;
        return_signal   = 1'b0;
        seed            = 32'h631c;
        repeat (10) @(negedge clock);
        resetn = 1'b1;
        repeat (4) @(negedge clock);

        for (int run = 0; run < 2; run++) begin
            pulse_start();
            wait_for_step(3'd1, SCREEN_W * SCREEN_H + leg_budget());
            for (int k = 2; k <= 5; k++) begin
                wait_for_step(step_t'(k), leg_budget());
            end
            wait_for_step(3'd0, leg_budget());   // Into done_animation
            repeat (3) @(negedge clock);
            return_and_wait_finish();
            repeat (8) @(negedge clock);
        end

        repeat (20) @(negedge clock);
        if (i_dut.i_checker.error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "Checker reported errors");
        end
    end

endmodule

`default_nettype wire

/* animation_top.sv */
// Frame buffer and VGA timing sit outside; pixel outputs lag stage writes by one cycle
`timescale 1ns/1ps
`default_nettype none

module animation_top import anim_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     start_animation,
    input  logic     return_signal,
    output coord_x_t pix_x,
    output coord_y_t pix_y,
    output colour_t  pix_colour,
    output logic     plot,
    output step_t    step,
    output logic     finished_transaction
);

    anim_ctrl_if ctrl_if ();
    pixel_if     load_pix ();
    pixel_if     move_pix ();
    pixel_if     hold_pix ();

    animations_control i_control (
        .clock                (clock),
        .resetn               (resetn),
        .start_animation      (start_animation),
        .return_signal        (return_signal),
        .ctrl                 (ctrl_if.ctrl),
        .finished_transaction (finished_transaction)
    );

    screen_loader i_loader (
        .clock  (clock),
        .resetn (resetn),
        .ctrl   (ctrl_if.loader),
        .pix    (load_pix.source)
    );

    travel_animator i_mover (
        .clock  (clock),
        .resetn (resetn),
        .ctrl   (ctrl_if.mover),
        .pix    (move_pix.source)
    );

    step_timer i_holder (
        .clock  (clock),
        .resetn (resetn),
        .ctrl   (ctrl_if.holder),
        .pix    (hold_pix.source)
    );

    pixel_writer i_writer (
        .clock      (clock),
        .resetn     (resetn),
        .load_pix   (load_pix.sink),
        .move_pix   (move_pix.sink),
        .hold_pix   (hold_pix.sink),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour),
        .plot       (plot)
    );

    assign step = ctrl_if.step;   // Current station for the display logic

endmodule

`default_nettype wire

/* animations_control.sv */
// Outputs decode from state only; return_signal is ignored outside done_animation
`timescale 1ns/1ps
`default_nettype none

module animations_control import anim_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        start_animation,
    input  logic        return_signal,
    anim_ctrl_if.ctrl   ctrl,
    output logic        finished_transaction
);

    anim_state_t state, state_next;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            st_buffer:               if (start_animation)   state_next = st_start;
            st_start:                if (ctrl.done_display) state_next = st_travel1;
            st_travel1:              if (ctrl.done_travel)  state_next = st_verify_amount;
            st_verify_amount:        if (ctrl.done_step)    state_next = st_travel2;
            st_travel2:              if (ctrl.done_travel)  state_next = st_verify_signature;
            st_verify_signature:     if (ctrl.done_step)    state_next = st_travel3;
            st_travel3:              if (ctrl.done_travel)  state_next = st_finalize_transaction;
            st_finalize_transaction: if (ctrl.done_step)    state_next = st_travel4;
            st_travel4:              if (ctrl.done_travel)  state_next = st_mine_block;
            st_mine_block:           if (ctrl.done_step)    state_next = st_travel5;
            st_travel5:              if (ctrl.done_travel)  state_next = st_update_chain;
            st_update_chain:         if (ctrl.done_step)    state_next = st_done_animation;
            st_done_animation:       if (return_signal)     state_next = st_buffer;
            default:                 state_next = st_buffer;
        endcase
    end

    // Stage requests
    always_comb begin
        ctrl.load_screen = 1'b0;
        ctrl.travel      = 3'd0;
        ctrl.step        = 3'd0;
        case (state)
            st_start: ctrl.load_screen = 1'b1;
            st_travel1: begin
                ctrl.travel = 3'd1;
                ctrl.step   = 3'd1;
            end
            st_verify_amount:        ctrl.step = 3'd1;
            st_travel2: begin
                ctrl.travel = 3'd2;
                ctrl.step   = 3'd2;
            end
            st_verify_signature:     ctrl.step = 3'd2;
            st_travel3: begin
                ctrl.travel = 3'd3;
                ctrl.step   = 3'd3;
            end
            st_finalize_transaction: ctrl.step = 3'd3;
            st_travel4: begin
                ctrl.travel = 3'd4;
                ctrl.step   = 3'd4;
            end
            st_mine_block:           ctrl.step = 3'd4;
            st_travel5: begin
                ctrl.travel = 3'd5;
                ctrl.step   = 3'd5;
            end
            st_update_chain:         ctrl.step = 3'd5;
            default: ;               // buffer and done_animation leave all low
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state                <= st_buffer;
            finished_transaction <= 1'b0;
        end else begin
            state                <= state_next;
            // Same edge that takes the state back to buffer
            finished_transaction <= (state == st_done_animation) && return_signal;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
anim_pkg.sv
anim_if.sv
animations_control.sv
screen_loader.sv
travel_animator.sv
step_timer.sv
pixel_writer.sv
animation_top.sv
animation_checker.sv
animation_tb.sv

/* pixel_writer.sv */
// Sources never write together; loader wins, then mover, then holder
`timescale 1ns/1ps
`default_nettype none

module pixel_writer import anim_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    pixel_if.sink    load_pix,
    pixel_if.sink    move_pix,
    pixel_if.sink    hold_pix,
    output coord_x_t pix_x,
    output coord_y_t pix_y,
    output colour_t  pix_colour,
    output logic     plot
);

    coord_x_t sel_x;
    coord_y_t sel_y;
    colour_t  sel_colour;

    always_comb begin
        if (load_pix.plot) begin
            sel_x      = load_pix.x;
            sel_y      = load_pix.y;
            sel_colour = load_pix.colour;
        end else if (move_pix.plot) begin
            sel_x      = move_pix.x;
            sel_y      = move_pix.y;
            sel_colour = move_pix.colour;
        end else begin
            sel_x      = hold_pix.x;
            sel_y      = hold_pix.y;
            sel_colour = hold_pix.colour;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) plot <= 1'b0;
        else         plot <= load_pix.plot | move_pix.plot | hold_pix.plot;
    end

    // Payload follows the strobe, only meaningful while plot is high
    always_ff @(posedge clock) begin
        pix_x      <= sel_x;
        pix_y      <= sel_y;
        pix_colour <= sel_colour;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module animation_tb \
    -f compile.f -o animation_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/animation_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* screen_loader.sv */
// Clears the whole frame in raster order, one pixel per cycle, on each load_screen rise
`timescale 1ns/1ps
`default_nettype none

module screen_loader import anim_pkg::*; (
    input  logic         clock,
    input  logic         resetn,
    anim_ctrl_if.loader  ctrl,
    pixel_if.source      pix
);

    logic     load_q;
    logic     busy;
    coord_x_t x_cnt;
    coord_y_t y_cnt;
    logic     last_x, last_y;

    assign last_x = (x_cnt == coord_x_t'(SCREEN_W - 1));
    assign last_y = (y_cnt == coord_y_t'(SCREEN_H - 1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            load_q            <= 1'b0;
            busy              <= 1'b0;
            ctrl.done_display <= 1'b0;
            x_cnt             <= '0;
            y_cnt             <= '0;
        end else begin
            load_q            <= ctrl.load_screen;
            ctrl.done_display <= busy && last_x && last_y;   // After the final pixel
            if (ctrl.load_screen && !load_q) begin
                busy  <= 1'b1;
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (busy) begin
                if (last_x) begin
                    x_cnt <= '0;
                    y_cnt <= y_cnt + 1'b1;
                    if (last_y) busy <= 1'b0;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    assign pix.x      = x_cnt;
    assign pix.y      = y_cnt;
    assign pix.colour = COL_BG;
    assign pix.plot   = busy;

endmodule

`default_nettype wire

/* step_timer.sv */
// Starts when travel drops to 0 with step set; paints an 8x8 box above the path
`timescale 1ns/1ps
`default_nettype none

module step_timer import anim_pkg::*; (
    input  logic         clock,
    input  logic         resetn,
    anim_ctrl_if.holder  ctrl,
    pixel_if.source      pix
);

    typedef enum logic [1:0] {h_idle, h_hold, h_paint, h_done} hold_state_t;

    hold_state_t       state;
    step_t             travel_q;
    step_t             station;     // Station whose box gets painted
    logic [HOLD_W-1:0] hold_cnt;
    logic [5:0]        box_idx;     // Column in bits 2:0, row in bits 5:3
    logic              enter_step;

    assign enter_step = (travel_q != 3'd0) && (ctrl.travel == 3'd0) && (ctrl.step != 3'd0);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= h_idle;
            travel_q <= 3'd0;
            station  <= 3'd0;
            hold_cnt <= '0;
            box_idx  <= '0;
        end else begin
            travel_q <= ctrl.travel;
            case (state)
                h_idle: if (enter_step) begin
                    state    <= h_hold;
                    station  <= ctrl.step;
                    hold_cnt <= '0;
                end
                h_hold: begin
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == HOLD_W'(HOLD_CYCLES - 1)) begin
                        state   <= h_paint;
                        box_idx <= '0;
                    end
                end
                h_paint: begin
                    box_idx <= box_idx + 1'b1;
                    if (box_idx == 6'd63) state <= h_done;
                end
                default: state <= h_idle;
            endcase
        end
    end

    assign ctrl.done_step = (state == h_done);

    assign pix.x      = station_x(station) + coord_x_t'(box_idx[2:0]);
    assign pix.y      = coord_y_t'(BOX_Y) + coord_y_t'(box_idx[5:3]);
    assign pix.colour = COL_BOX;
    assign pix.plot   = (state == h_paint);

endmodule

`default_nettype wire

/* travel_animator.sv */
// Token moves one column per MOVE_CYCLES; travel must return to 0 between legs
`timescale 1ns/1ps
`default_nettype none

module travel_animator import anim_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    anim_ctrl_if.mover  ctrl,
    pixel_if.source     pix
);

    typedef enum logic [2:0] {
        m_idle,
        m_draw,
        m_wait,
        m_erase,
        m_finish
    } move_state_t;

    move_state_t       state;
    step_t             travel_q;
    coord_x_t          token_x;
    coord_x_t          end_x;
    logic [3:0]        pix_idx;    // Two low bits column, two high bits row
    logic [MOVE_W-1:0] move_cnt;
    logic              start_leg;

    assign start_leg = (ctrl.travel != 3'd0) && (travel_q == 3'd0);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= m_idle;
            travel_q <= 3'd0;
            pix_idx  <= '0;
            move_cnt <= '0;
        end else begin
            travel_q <= ctrl.travel;
            case (state)
                m_idle: begin
                    if (start_leg) begin
                        state   <= m_draw;
                        pix_idx <= '0;
                    end
                end
                m_draw: begin
                    pix_idx <= pix_idx + 1'b1;
                    if (pix_idx == 4'hf) begin
                        if (token_x == end_x) begin
                            state <= m_finish;   // Arrived at the next station
                        end else begin
                            state    <= m_wait;
                            move_cnt <= '0;
                        end
                    end
                end
                m_wait: begin
                    move_cnt <= move_cnt + 1'b1;
                    if (move_cnt == MOVE_W'(MOVE_CYCLES - 1)) begin
                        state   <= m_erase;
                        pix_idx <= '0;
                    end
                end
                m_erase: begin
                    pix_idx <= pix_idx + 1'b1;
                    if (pix_idx == 4'hf) state <= m_draw;
                end
                default: state <= m_idle;     // m_finish lasts one cycle
            endcase
        end
    end

    // Token column and the column where the leg ends
    always_ff @(posedge clock) begin
        if (state == m_idle && start_leg) begin
            token_x <= station_x(step_t'(ctrl.travel - 3'd1));
            end_x   <= station_x(ctrl.travel);
        end else if (state == m_erase && pix_idx == 4'hf) begin
            token_x <= token_x + 1'b1;
        end
    end

    assign ctrl.done_travel = (state == m_finish);

    assign pix.x      = token_x + coord_x_t'(pix_idx[1:0]);
    assign pix.y      = coord_y_t'(PATH_Y) + coord_y_t'(pix_idx[3:2]);
    assign pix.colour = (state == m_erase) ? COL_BG : COL_TOKEN;
    assign pix.plot   = (state == m_draw) || (state == m_erase);

endmodule

`default_nettype wire
